// File: hdl/fwrisc_pkg.sv
package fwrisc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath width
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	parameter int XLEN = 32;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// rv32i major opcodes in use
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	parameter logic [6:0] OPC_LUI    = 7'b0110111;
	parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
	parameter logic [6:0] OPC_OP     = 7'b0110011;
	parameter logic [6:0] OPC_LOAD   = 7'b0000011;
	parameter logic [6:0] OPC_STORE  = 7'b0100011;
	parameter logic [6:0] OPC_BRANCH = 7'b1100011;
	parameter logic [6:0] OPC_JAL    = 7'b1101111;
	parameter logic [6:0] OPC_SYSTEM = 7'b1110011; // ecall only

	// alu operations
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5 // signed compare
	} alu_op_t;

	// core sequencing states, one instruction in flight
	typedef enum logic [2:0] {
		HALT  = 3'd0,
		FETCH = 3'd1,
		EXEC  = 3'd2,
		MEM   = 3'd3, // load data return
		WB    = 3'd4
	} core_state_t;

endpackage

// File: hdl/fwrisc_mem_if.sv
interface fwrisc_mem_if #(
	parameter int MEM_AW = 12
) ();
	import fwrisc_pkg::*;

	logic [MEM_AW-1:0] addr;  // word address
	logic [XLEN-1:0]   wdata;
	logic [XLEN-1:0]   rdata; // valid the cycle after a read
	logic [3:0]        strb;  // byte lanes for writes
	logic              write;
	logic              valid;

	modport core (
		output addr,
		output wdata,
		output strb,
		output write,
		output valid,
		input  rdata
	);

	modport sram (
		input  addr,
		input  wdata,
		input  strb,
		input  write,
		input  valid,
		output rdata
	);

endinterface

// File: hdl/fwrisc_regfile.sv
module fwrisc_regfile (
	input  logic                        clock,
	input  logic                        i_rst_n,
	input  logic [4:0]                  i_ra_addr,
	input  logic [4:0]                  i_rb_addr,
	output logic [fwrisc_pkg::XLEN-1:0] o_ra_data,
	output logic [fwrisc_pkg::XLEN-1:0] o_rb_data,
	input  logic [4:0]                  i_rd_addr,
	input  logic [fwrisc_pkg::XLEN-1:0] i_rd_wdata,
	input  logic                        i_rd_we
);
	import fwrisc_pkg::*;

	// x0 has no storage
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_rd_we && (i_rd_addr != 5'd0)) begin
			regs[i_rd_addr] <= i_rd_wdata;
		end
	end

	// async read ports, x0 reads back as zero
	always_comb begin
		if (i_ra_addr == 5'd0) begin
			o_ra_data = '0;
		end else begin
			o_ra_data = regs[i_ra_addr];
		end
	end

	always_comb begin
		if (i_rb_addr == 5'd0) begin
			o_rb_data = '0;
		end else begin
			o_rb_data = regs[i_rb_addr];
		end
	end

endmodule

// File: hdl/fwrisc_alu.sv
module fwrisc_alu (
	input  fwrisc_pkg::alu_op_t         i_op,
	input  logic [fwrisc_pkg::XLEN-1:0] i_a,
	input  logic [fwrisc_pkg::XLEN-1:0] i_b,
	output logic [fwrisc_pkg::XLEN-1:0] o_result,
	output logic                        o_eq
);
	import fwrisc_pkg::*;

	logic lt_signed;

	assign lt_signed = ($signed(i_a) < $signed(i_b));

	always_comb begin
		case (i_op)
			ALU_ADD: begin
				o_result = i_a + i_b;
			end
			ALU_SUB: begin
				o_result = i_a - i_b;
			end
			ALU_AND: begin
				o_result = i_a & i_b;
			end
			ALU_OR: begin
				o_result = i_a | i_b;
			end
			ALU_XOR: begin
				o_result = i_a ^ i_b;
			end
			ALU_SLT: begin
				o_result = {{(XLEN-1){1'b0}}, lt_signed};
			end
			default: begin
				o_result = i_a + i_b;
			end
		endcase
	end

	assign o_eq = (i_a == i_b); // for beq/bne

endmodule

// File: hdl/fwrisc_core.sv
module fwrisc_core #(
	parameter int MEM_AW = 12
) (
	input  logic                        clock,
	input  logic                        i_rst_n,
	input  logic                        i_run,
	input  logic                        i_load_we,
	input  logic [MEM_AW-1:0]           i_load_addr,
	input  logic [fwrisc_pkg::XLEN-1:0] i_load_data,
	fwrisc_mem_if.core                  imem,
	fwrisc_mem_if.core                  dmem,
	output logic                        o_halted,
	output logic                        o_commit,
	output logic [fwrisc_pkg::XLEN-1:0] o_commit_pc,
	output logic [4:0]                  o_commit_rd,
	output logic [fwrisc_pkg::XLEN-1:0] o_commit_wdata
);
	import fwrisc_pkg::*;

	core_state_t     state;
	logic            run_q;
	logic            halt_q;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_next_q;
	logic [XLEN-1:0] res_q;
	logic [4:0]      rd_q;

	logic [XLEN-1:0] instr;
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] ra_data;
	logic [XLEN-1:0] rb_data;
	alu_op_t         alu_op;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_res;
	logic            alu_eq;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_target;
	logic [XLEN-1:0] res_d;
	logic [XLEN-1:0] pc_next_d;
	logic [4:0]      rd_d;
	logic            halt_d;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign instr  = imem.rdata; // only meaningful in EXEC
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		alu_op = ALU_ADD; // address calc for ld/st
		if ((opcode == OPC_OP) || (opcode == OPC_OP_IMM)) begin
			case (funct3)
				3'b000: alu_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
				3'b010: alu_op = ALU_SLT;
				3'b100: alu_op = ALU_XOR;
				3'b110: alu_op = ALU_OR;
				3'b111: alu_op = ALU_AND;
				default: alu_op = ALU_ADD;
			endcase
		end
	end

	// register operand for op and branch compare, immediate otherwise
	assign alu_b = ((opcode == OPC_OP) || (opcode == OPC_BRANCH)) ? rb_data :
		(opcode == OPC_STORE) ? imm_s : imm_i;

	fwrisc_regfile u_regfile (
		.clock      (clock),
		.i_rst_n    (i_rst_n),
		.i_ra_addr  (instr[19:15]),
		.i_rb_addr  (instr[24:20]),
		.o_ra_data  (ra_data),
		.o_rb_data  (rb_data),
		.i_rd_addr  (rd_q),
		.i_rd_wdata (res_q),
		.i_rd_we    (state == WB) // x0 writes dropped inside
	);

	fwrisc_alu u_alu (
		.i_op     (alu_op),
		.i_a      (ra_data),
		.i_b      (alu_b),
		.o_result (alu_res),
		.o_eq     (alu_eq)
	);

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + ((opcode == OPC_JAL) ? imm_j : imm_b);

	// result, destination and next pc of the instruction in EXEC
	always_comb begin
		res_d     = '0;
		rd_d      = 5'd0;
		pc_next_d = pc_plus4;
		halt_d    = 1'b0;
		case (opcode)
			OPC_LUI: begin
				res_d = imm_u;
				rd_d  = instr[11:7];
			end
			OPC_OP_IMM, OPC_OP: begin
				res_d = alu_res;
				rd_d  = instr[11:7];
			end
			OPC_LOAD: begin
				rd_d = instr[11:7]; // data arrives in MEM
			end
			OPC_STORE: begin
				rd_d = 5'd0;
			end
			OPC_BRANCH: begin
				if (alu_eq ^ funct3[0]) begin // beq 000, bne 001
					pc_next_d = pc_target;
				end
			end
			OPC_JAL: begin
				res_d     = pc_plus4; // link
				rd_d      = instr[11:7];
				pc_next_d = pc_target;
			end
			OPC_SYSTEM: begin
				halt_d = 1'b1;
			end
			default: begin
				halt_d = 1'b1; // unknown opcode acts as ecall
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory ports
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		if (state == HALT) begin
			// host program load
			imem.valid = i_load_we;
			imem.write = 1'b1;
			imem.addr  = i_load_addr;
			imem.wdata = i_load_data;
			imem.strb  = 4'hf;
		end else begin
			imem.valid = (state == FETCH);
			imem.write = 1'b0;
			imem.addr  = pc[MEM_AW+1:2];
			imem.wdata = '0;
			imem.strb  = 4'hf;
		end
	end

	always_comb begin
		dmem.valid = (state == EXEC) && ((opcode == OPC_LOAD) || (opcode == OPC_STORE));
		dmem.write = (opcode == OPC_STORE);
		dmem.addr  = alu_res[MEM_AW+1:2];
		if (funct3 == 3'b000) begin
			// sb, byte copied to every lane
			dmem.strb  = 4'b0001 << alu_res[1:0];
			dmem.wdata = {4{rb_data[7:0]}};
		end else begin
			dmem.strb  = 4'hf;
			dmem.wdata = rb_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state  <= HALT;
			run_q  <= 1'b0;
			halt_q <= 1'b0;
			pc     <= '0;
		end else begin
			run_q <= i_run;
			case (state)
				HALT: begin
					if (i_run && !run_q) begin // rising edge of run
						pc    <= '0;
						state <= FETCH;
					end
				end
				FETCH: state <= EXEC;
				EXEC: begin
					halt_q <= halt_d;
					state  <= (opcode == OPC_LOAD) ? MEM : WB;
				end
				MEM: state <= WB;
				WB: begin
					pc    <= pc_next_q;
					state <= halt_q ? HALT : FETCH;
				end
				default: state <= HALT;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == EXEC) begin
			res_q     <= res_d;
			rd_q      <= rd_d;
			pc_next_q <= pc_next_d;
		end else if (state == MEM) begin
			res_q <= dmem.rdata; // lw result
		end
	end

	assign o_halted       = (state == HALT);
	assign o_commit       = (state == WB);
	assign o_commit_pc    = pc;
	assign o_commit_rd    = rd_q;
	assign o_commit_wdata = res_q;

endmodule

// File: hdl/fwrisc_tracer.sv
module fwrisc_tracer (
	input  logic                        clock,
	input  logic                        i_rst_n,
	input  logic                        i_commit,
	input  logic [fwrisc_pkg::XLEN-1:0] i_pc,
	input  logic [4:0]                  i_rd,
	input  logic [fwrisc_pkg::XLEN-1:0] i_wdata,
	output logic                        o_retire_valid,
	output logic [fwrisc_pkg::XLEN-1:0] o_retire_pc,
	output logic [4:0]                  o_retire_rd,
	output logic [fwrisc_pkg::XLEN-1:0] o_retire_wdata,
	output logic [31:0]                 o_retire_count
);

	// control: strobe and running count
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_retire_valid <= 1'b0;
			o_retire_count <= 32'd0;
		end else begin
			o_retire_valid <= i_commit; // one cycle after WB
			if (i_commit) begin
				o_retire_count <= o_retire_count + 32'd1;
			end
		end
	end

	// record of the last committed instruction
	always_ff @(posedge clock) begin
		if (i_commit) begin
			o_retire_pc    <= i_pc;
			o_retire_rd    <= i_rd;
			o_retire_wdata <= i_wdata;
		end
	end

endmodule

// File: hdl/fwrisc_sram_dp.sv
module fwrisc_sram_dp #(
	parameter int MEM_AW = 12
) (
	input logic        clock,
	fwrisc_mem_if.sram a,
	fwrisc_mem_if.sram b
);
	import fwrisc_pkg::*;

	localparam int DEPTH = 1 << MEM_AW;

	logic [XLEN-1:0] mem [0:DEPTH-1];

	// both ports in one process so that port B wins a same-word write
	always_ff @(posedge clock) begin
		if (a.valid && a.write) begin
			for (int i = 0; i < 4; i++) begin
				if (a.strb[i]) begin
					mem[a.addr][8*i +: 8] <= a.wdata[8*i +: 8];
				end
			end
		end
		if (b.valid && b.write) begin
			for (int i = 0; i < 4; i++) begin
				if (b.strb[i]) begin
					mem[b.addr][8*i +: 8] <= b.wdata[8*i +: 8];
				end
			end
		end
		if (a.valid && !a.write) begin
			a.rdata <= mem[a.addr]; // one cycle latency
		end
		if (b.valid && !b.write) begin
			b.rdata <= mem[b.addr];
		end
	end

endmodule

// File: hdl/fwrisc_top.sv
module fwrisc_top #(
	parameter int MEM_AW = 12 // 16 KB
) (
	input  logic                        clock,
	input  logic                        i_rst_n,
	input  logic                        i_run,
	input  logic                        i_load_we,
	input  logic [MEM_AW-1:0]           i_load_addr,
	input  logic [fwrisc_pkg::XLEN-1:0] i_load_data,
	output logic                        o_halted,
	output logic                        o_retire_valid,
	output logic [fwrisc_pkg::XLEN-1:0] o_retire_pc,
	output logic [4:0]                  o_retire_rd,
	output logic [fwrisc_pkg::XLEN-1:0] o_retire_wdata,
	output logic [31:0]                 o_retire_count
);
	import fwrisc_pkg::*;

	logic            commit;
	logic [XLEN-1:0] commit_pc;
	logic [4:0]      commit_rd;
	logic [XLEN-1:0] commit_wdata;

	fwrisc_mem_if #(.MEM_AW(MEM_AW)) imem_if (); // port A
	fwrisc_mem_if #(.MEM_AW(MEM_AW)) dmem_if (); // port B

	fwrisc_core #(.MEM_AW(MEM_AW)) u_core (
		.clock          (clock),
		.i_rst_n        (i_rst_n),
		.i_run          (i_run),
		.i_load_we      (i_load_we),
		.i_load_addr    (i_load_addr),
		.i_load_data    (i_load_data),
		.imem           (imem_if.core),
		.dmem           (dmem_if.core),
		.o_halted       (o_halted),
		.o_commit       (commit),
		.o_commit_pc    (commit_pc),
		.o_commit_rd    (commit_rd),
		.o_commit_wdata (commit_wdata)
	);

	fwrisc_tracer u_tracer (
		.clock          (clock),
		.i_rst_n        (i_rst_n),
		.i_commit       (commit),
		.i_pc           (commit_pc),
		.i_rd           (commit_rd),
		.i_wdata        (commit_wdata),
		.o_retire_valid (o_retire_valid),
		.o_retire_pc    (o_retire_pc),
		.o_retire_rd    (o_retire_rd),
		.o_retire_wdata (o_retire_wdata),
		.o_retire_count (o_retire_count)
	);

	fwrisc_sram_dp #(.MEM_AW(MEM_AW)) u_sram (
		.clock (clock),
		.a     (imem_if.sram),
		.b     (dmem_if.sram)
	);

endmodule

// File: sim/fwrisc_tb_chk.sv
module fwrisc_tb_chk (
	input logic clock,
	input logic i_rst_n,
	input logic i_halted,
	input logic i_commit,
	input logic i_imem_valid,
	input logic i_imem_write,
	input logic i_dmem_valid,
	input logic i_dmem_write
);

	int fail_count = 0; // read by the testbench top

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory port rules
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_imem_write_halted: assert property (@(posedge clock) disable iff (!i_rst_n)
		(i_imem_valid && i_imem_write) |-> i_halted)
	else begin
		fail_count++;
		$error("imem write while the core is running");
	end

	a_no_dual_write: assert property (@(posedge clock) disable iff (!i_rst_n)
		!i_halted |-> !(i_imem_valid && i_imem_write && i_dmem_valid && i_dmem_write))
	else begin
		fail_count++;
		$error("imem and dmem both write in one cycle");
	end

	// commit strobe
	a_commit_pulse: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_commit |=> !i_commit)
	else begin
		fail_count++;
		$error("commit held for more than one cycle");
	end

	a_no_commit_halted: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_halted |-> !i_commit)
	else begin
		fail_count++;
		$error("commit raised while halted");
	end

endmodule

bind fwrisc_core fwrisc_tb_chk chk_i (
	.clock        (clock),
	.i_rst_n      (i_rst_n),
	.i_halted     (o_halted),
	.i_commit     (o_commit),
	.i_imem_valid (imem.valid),
	.i_imem_write (imem.write),
	.i_dmem_valid (dmem.valid),
	.i_dmem_write (dmem.write)
);

// File: sim/fwrisc_scoreboard.sv
module fwrisc_scoreboard #(
	parameter int MEM_AW = 12
) (
	input  logic              clock,
	input  logic              i_rst_n,
	input  logic              i_run,
	input  logic              i_load_we,
	input  logic [MEM_AW-1:0] i_load_addr,
	input  logic [31:0]       i_load_data,
	input  logic              i_halted,
	input  logic              i_retire_valid,
	input  logic [31:0]       i_retire_pc,
	input  logic [4:0]        i_retire_rd,
	input  logic [31:0]       i_retire_wdata,
	input  logic [31:0]       i_retire_count,
	input  logic              i_final,
	output int                o_mismatch_count,
	output int                o_other_count
);
	import fwrisc_pkg::*;

	logic [31:0] iss_regs [0:31];
	logic [31:0] iss_mem [0:(1<<MEM_AW)-1]; // sram mirror fed by host loads
	logic [31:0] iss_pc;
	logic [31:0] iss_retired;
	logic        iss_halted;
	logic        run_q;
	logic        reset_checked;
	string       test_name = "reset";

	task automatic start_test(input string name);
		test_name = name;
	endtask

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch in test %s: %s expected %h, actual %h", test_name, what, exp, act);
			o_mismatch_count++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference iss for one instruction
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic void iss_step(output logic [4:0] rd, output logic [31:0] wd,
			output logic halt);
		logic [31:0]       ins;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       addr;
		logic [31:0]       next_pc;
		logic [MEM_AW-1:0] w;
		ins     = iss_mem[iss_pc[MEM_AW+1:2]];
		a       = iss_regs[ins[19:15]];
		b       = iss_regs[ins[24:20]];
		next_pc = iss_pc + 32'd4;
		rd      = ins[11:7];
		wd      = '0;
		halt    = 1'b0;
		if (ins[6:0] == OPC_OP_IMM) begin
			b = {{20{ins[31]}}, ins[31:20]}; // immediate replaces rs2
		end
		case (ins[6:0])
			OPC_LUI: wd = {ins[31:12], 12'h000};
			OPC_OP_IMM, OPC_OP: begin
				case (ins[14:12])
					3'b000: wd = (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
					3'b010: wd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'b100: wd = a ^ b;
					3'b110: wd = a | b;
					3'b111: wd = a & b;
					default: wd = a + b;
				endcase
			end
			OPC_LOAD: begin
				addr = a + {{20{ins[31]}}, ins[31:20]};
				wd   = iss_mem[addr[MEM_AW+1:2]];
			end
			OPC_STORE: begin
				addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				w    = addr[MEM_AW+1:2];
				rd   = 5'd0;
				if (ins[14:12] == 3'b000) begin
					iss_mem[w][8*addr[1:0] +: 8] = b[7:0]; // sb
				end else begin
					iss_mem[w] = b;
				end
			end
			OPC_BRANCH: begin
				rd = 5'd0;
				if ((a == b) != ins[12]) begin
					next_pc = iss_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end
			end
			OPC_JAL: begin
				wd      = iss_pc + 32'd4;
				next_pc = iss_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			default: begin // ecall and unknown opcodes stop the core
				rd   = 5'd0;
				halt = 1'b1;
			end
		endcase
		if (rd != 5'd0) begin
			iss_regs[rd] = wd;
		end
		iss_pc = next_pc;
	endfunction

	always @(posedge clock) begin : compare
		logic [4:0]  exp_rd;
		logic [31:0] exp_wd;
		logic [31:0] exp_pc;
		logic        exp_halt;
		if (!i_rst_n) begin
			for (int i = 0; i < 32; i++) begin
				iss_regs[i] = '0;
			end
			iss_pc           = '0;
			iss_retired      = '0;
			iss_halted       = 1'b1;
			run_q            = 1'b0;
			reset_checked    = 1'b0;
			o_mismatch_count = 0;
			o_other_count    = 0;
		end else begin
			if (!reset_checked) begin
				reset_checked = 1'b1;
				check("halted after reset", 32'd1, {31'd0, i_halted});
				check("retire valid after reset", 32'd0, {31'd0, i_retire_valid});
				check("retire count after reset", 32'd0, i_retire_count);
			end
			if (i_halted && i_load_we) begin
				iss_mem[i_load_addr] = i_load_data;
			end
			if (i_halted && i_run && !run_q) begin
				if (!iss_halted) begin
					$display("error: no ecall retired before the run of test %s", test_name);
					o_other_count++;
				end
				iss_pc     = '0; // every run starts at pc 0
				iss_halted = 1'b0;
			end
			run_q = i_run;
			if (i_retire_valid) begin
				exp_pc = iss_pc;
				iss_step(exp_rd, exp_wd, exp_halt);
				iss_retired++;
				if (exp_halt) begin
					iss_halted = 1'b1;
				end
				check("pc", exp_pc, i_retire_pc);
				check("rd", {27'd0, exp_rd}, {27'd0, i_retire_rd});
				check("wdata", exp_wd, i_retire_wdata);
				check("retire count", iss_retired, i_retire_count);
				check("halted", {31'd0, exp_halt}, {31'd0, i_halted});
			end
			if (i_final) begin
				check("total retire count", iss_retired, i_retire_count);
				if (!i_halted) begin
					$display("error: core is not halted at the end of test %s", test_name);
					o_other_count++;
				end
				if (!iss_halted) begin
					$display("error: ecall of test %s never retired", test_name);
					o_other_count++;
				end
			end
		end
	end

endmodule

// File: sim/fwrisc_tb.sv
module fwrisc_tb;

	localparam int          MEM_AW = 12;
	localparam logic [31:0] ECALL  = 32'h0000_0073;
	localparam logic [6:0]  OPI    = 7'h13;
	localparam logic [6:0]  LOAD   = 7'h03;
	localparam logic [2:0]  ALU_F3 [5] = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7}; // add slt xor or and

	logic              clock;
	logic              i_rst_n;
	logic              i_run;
	logic              i_load_we;
	logic [MEM_AW-1:0] i_load_addr;
	logic [31:0]       i_load_data;
	logic              o_halted;
	logic              o_retire_valid;
	logic [31:0]       o_retire_pc;
	logic [4:0]        o_retire_rd;
	logic [31:0]       o_retire_wdata;
	logic [31:0]       o_retire_count;
	logic              final_check;
	int                mismatch_count;
	int                other_count;
	int                assert_count;
	int                seed = 32'he9c5;
	int                wait_cycles = 0;
	int                cycle_limit = 50;
	string             cur_test = "reset";
	logic [31:0]       prog [$];

	fwrisc_top #(.MEM_AW(MEM_AW)) fwrisc_top_i (.*);

	fwrisc_scoreboard #(.MEM_AW(MEM_AW)) sb_i (
		.clock            (clock),
		.i_rst_n          (i_rst_n),
		.i_run            (i_run),
		.i_load_we        (i_load_we),
		.i_load_addr      (i_load_addr),
		.i_load_data      (i_load_data),
		.i_halted         (o_halted),
		.i_retire_valid   (o_retire_valid),
		.i_retire_pc      (o_retire_pc),
		.i_retire_rd      (o_retire_rd),
		.i_retire_wdata   (o_retire_wdata),
		.i_retire_count   (o_retire_count),
		.i_final          (final_check),
		.o_mismatch_count (mismatch_count),
		.o_other_count    (other_count)
	);

	assign assert_count = fwrisc_top_i.u_core.chk_i.fail_count;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction encoders
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] itype(logic [6:0] opc, logic [4:0] rd, logic [2:0] f3,
			logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] rtype(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] stype(logic [2:0] f3, logic [4:0] rs2, logic [4:0] rs1,
			logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] btype(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
			logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] utype(logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, 7'h37};
	endfunction

	function automatic logic [31:0] jtype(logic [4:0] rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	// lui, op-imm or op with random registers and immediate
	function automatic logic [31:0] random_reg_op();
		logic [31:0] r;
		logic [31:0] s;
		logic [2:0]  f3;
		r  = rnd();
		s  = rnd();
		f3 = ALU_F3[s[2:0] % 5];
		if (s[4:3] == 2'b00) begin
			return utype(r[4:0], s[31:12]);
		end else if (s[4]) begin
			return itype(OPI, r[4:0], f3, r[9:5], r[31:20]);
		end
		return rtype((f3 == 3'd0 && s[5]) ? 7'h20 : 7'h00, r[14:10], r[9:5], f3, r[4:0]);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test programs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic void alu_program();
		prog.delete();
		prog.push_back(itype(OPI, 5'd0, 3'd0, 5'd0, 12'd123)); // x0 write is dropped
		prog.push_back(rtype(7'h00, 5'd0, 5'd0, 3'd0, 5'd5));  // reads x0 back as zero
		for (int n = 0; n < 40; n++) begin
			prog.push_back(random_reg_op());
		end
		prog.push_back(ECALL);
	endfunction

	function automatic void ldst_program();
		logic [31:0] r;
		logic [31:0] s;
		logic [11:0] off;
		prog.delete();
		prog.push_back(itype(OPI, 5'd10, 3'd0, 5'd0, 12'h400)); // data area base
		for (int n = 0; n < 6; n++) begin
			r   = rnd();
			s   = rnd();
			off = {4'd0, r[5:0], 2'b00};
			prog.push_back(utype(5'd11, s[31:12]));
			prog.push_back(itype(OPI, 5'd11, 3'd0, 5'd11, s[11:0]));
			prog.push_back(stype(3'b010, 5'd11, 5'd10, off));
			prog.push_back(itype(OPI, 5'd12, 3'd0, 5'd0, r[17:6]));
			prog.push_back(stype(3'b000, 5'd12, 5'd10, off + {10'd0, r[19:18]})); // sb merge
			prog.push_back(itype(LOAD, 5'd13, 3'b010, 5'd10, off));
		end
		prog.push_back(ECALL);
	endfunction

	function automatic void branch_program();
		prog.delete();
		prog.push_back(itype(OPI, 5'd1, 3'd0, 5'd0, 12'd3));   // loop count
		prog.push_back(itype(OPI, 5'd2, 3'd0, 5'd0, 12'd0));
		prog.push_back(itype(OPI, 5'd2, 3'd0, 5'd2, 12'd5));   // loop body
		prog.push_back(itype(OPI, 5'd1, 3'd0, 5'd1, 12'hfff));
		prog.push_back(btype(3'b001, 5'd1, 5'd0, -13'sd8));    // bne back
		prog.push_back(btype(3'b000, 5'd2, 5'd0, 13'd8));      // beq not taken
		prog.push_back(itype(OPI, 5'd3, 3'd0, 5'd0, 12'd1));
		prog.push_back(btype(3'b000, 5'd1, 5'd0, 13'd8));      // beq taken
		prog.push_back(itype(OPI, 5'd3, 3'd0, 5'd0, 12'd99));
		prog.push_back(jtype(5'd4, 21'd12));                   // link 40
		prog.push_back(itype(OPI, 5'd3, 3'd0, 5'd0, 12'd77));
		prog.push_back(itype(OPI, 5'd3, 3'd0, 5'd0, 12'd88));
		prog.push_back(btype(3'b001, 5'd2, 5'd3, 13'd8));      // bne taken
		prog.push_back(itype(OPI, 5'd3, 3'd0, 5'd0, 12'd55));
		prog.push_back(jtype(5'd0, 21'd8));
		prog.push_back(itype(OPI, 5'd3, 3'd0, 5'd0, 12'd66));
		prog.push_back(rtype(7'h00, 5'd0, 5'd4, 3'd0, 5'd5));
		prog.push_back(ECALL);
	endfunction

	// relies on x2, x4, x10 and x13 left by earlier tests
	function automatic void rerun_program();
		prog.delete();
		prog.push_back(rtype(7'h00, 5'd2, 5'd4, 3'd0, 5'd6));
		prog.push_back(rtype(7'h00, 5'd13, 5'd6, 3'd4, 5'd7));
		prog.push_back(stype(3'b010, 5'd7, 5'd10, 12'h100));
		prog.push_back(itype(LOAD, 5'd8, 3'b010, 5'd10, 12'h100));
		for (int n = 0; n < 10; n++) begin
			prog.push_back(random_reg_op());
		end
		prog.push_back(ECALL);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host load and run control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			@(negedge clock);
			i_load_we   = 1'b1;
			i_load_addr = i[MEM_AW-1:0];
			i_load_data = prog[i];
		end
		@(negedge clock);
		i_load_we = 1'b0;
	endtask

	task automatic run_program(input string name);
		sb_i.start_test(name);
		cur_test    = name;
		wait_cycles = 0;
		cycle_limit = prog.size() * 4 + 50;
		@(negedge clock);
		i_run = 1'b1;
		@(negedge clock);
		i_run = 1'b0;
		while (!o_halted) begin
			@(negedge clock);
			wait_cycles++;
		end
		repeat (2) @(negedge clock); // last retire shows one cycle after halt
	endtask

	initial begin : watchdog
		wait (wait_cycles > cycle_limit);
		$display("timeout: core never halted in test %s within %0d cycles", cur_test, cycle_limit);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		i_rst_n     = 1'b0;
		i_run       = 1'b0;
		i_load_we   = 1'b0;
		i_load_addr = '0;
		i_load_data = '0;
		final_check = 1'b0;
		repeat (2) @(negedge clock);
		i_rst_n = 1'b1;
		@(negedge clock);

		alu_program();
		load_program();
		run_program("alu");
		ldst_program();
		load_program();
		run_program("ldst");
		branch_program();
		load_program();
		run_program("branch");
		rerun_program();
		load_program();
		run_program("rerun");
		run_program("rerun"); // same image, again from pc 0

		final_check = 1'b1;
		@(negedge clock);
		final_check = 1'b0;
		@(negedge clock);
		$display("done: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatch_count, other_count, assert_count);
		if (mismatch_count + other_count + assert_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
hdl/fwrisc_pkg.sv
hdl/fwrisc_mem_if.sv
hdl/fwrisc_regfile.sv
hdl/fwrisc_alu.sv
hdl/fwrisc_core.sv
hdl/fwrisc_tracer.sv
hdl/fwrisc_sram_dp.sv
hdl/fwrisc_top.sv
sim/fwrisc_tb_chk.sv
sim/fwrisc_scoreboard.sv
sim/fwrisc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# verilator build and run of the fwrisc testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module fwrisc_tb -f flist.f \
	-Mdir obj_dir -o fwrisc_sim

# pass or fail comes from the log
./obj_dir/fwrisc_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation PASSED" sim.log; then
	echo "run.sh: pass"
else
	echo "run.sh: fail"
	exit 1
fi
